// ==== verilog/issue_pkg.sv ====
package issue_pkg;

        // Physical register file size and the index width it implies.
        localparam int PHY_REGS = 46;
        localparam int IDX_W    = $clog2(PHY_REGS);

        typedef logic [IDX_W-1:0] phy_idx_t;
        typedef logic [31:0]      word_t;

        // The PC lives in the physical map like any other register.
        localparam phy_idx_t   ARCH_PC    = phy_idx_t'(15);
        localparam logic [3:0] COND_NV    = 4'hF;
        localparam logic [2:0] SHIFT_LSL  = 3'd0;
        // Rotate of an immediate, internal to the core.
        localparam logic [2:0] SHIFT_RORI = 3'd4;
        localparam logic [4:0] ALU_MLA    = 5'h11;

        // An immediate value or a register index in the low bits.
        typedef struct packed {
                logic  immed;
                word_t val;
        } operand_t;

        typedef struct packed {
                logic [3:0] cond;
                phy_idx_t   dest_idx;
                logic [4:0] alu_op;
                logic [2:0] shift_op;
                logic       flag_update;
                phy_idx_t   mem_srcdest_idx;
                logic       mem_load;
                logic       mem_store;
                logic       mem_pre_index;
                logic       mem_ubyte_en;
                logic       mem_sbyte_en;
                logic       mem_shalf_en;
                logic       mem_uhalf_en;
                logic       mem_translate;
                logic       irq;
                logic       fiq;
                logic       abt;
                logic       swi;
        } issue_ctrl_t;

        typedef struct packed {
                issue_ctrl_t ctrl;
                word_t       pc_plus_8;
                operand_t    alu_source;
                operand_t    shift_source;
                operand_t    shift_length;
        } decode_pkt_t;

        // Results fed back from the later stages.
        typedef struct packed {
                phy_idx_t shifter_dest_idx;
                logic     alu_dav_nxt;
                word_t    alu_value_nxt;
                phy_idx_t alu_dest_idx;
                logic     alu_dav_ff;
                word_t    alu_value_ff;
                phy_idx_t mem_dest_idx;
                logic     mem_dav_ff;
                word_t    mem_value_ff;
                phy_idx_t mem_srcdest_idx;
                logic     mem_load;
                word_t    mem_load_data;
        } fwd_bus_t;

        typedef struct packed {
                phy_idx_t shifter_mem_srcdest_idx;
                logic     shifter_mem_load;
                phy_idx_t alu_mem_srcdest_idx;
                logic     alu_mem_load;
        } load_track_t;

        typedef struct packed {
                issue_ctrl_t ctrl;
                word_t       pc_plus_8;
                operand_t    alu_source;
                operand_t    shift_source;
                operand_t    shift_length;
                word_t       alu_source_value;
                word_t       shift_source_value;
                word_t       shift_length_value;
                word_t       mem_srcdest_value;
                logic        shifter_disable;
        } issue_pkt_t;

endpackage

// ==== verilog/operand_resolver.sv ====
`timescale 1ns/1ps

module operand_resolver (
        input  issue_pkg::operand_t i_operand,
        input  issue_pkg::word_t    i_pc_plus_8,
        input  issue_pkg::word_t    i_rd_data,
        input  issue_pkg::fwd_bus_t i_fwd,
        output issue_pkg::word_t    o_value
);

        issue_pkg::phy_idx_t idx;
        logic                is_reg;
        logic                accel_hit;
        issue_pkg::word_t    fwd_value;

        assign idx    = i_operand.val[issue_pkg::IDX_W-1:0];
        assign is_reg = !i_operand.immed;

        // Newest producer wins, so the ALU result being computed now
        // is checked before anything registered.
        always_comb
        begin
                if (!is_reg)
                        fwd_value = i_operand.val;
                else if (idx == issue_pkg::ARCH_PC)
                        fwd_value = i_pc_plus_8;
                else if (idx == i_fwd.shifter_dest_idx && i_fwd.alu_dav_nxt)
                        fwd_value = i_fwd.alu_value_nxt;
                else if (idx == i_fwd.alu_dest_idx && i_fwd.alu_dav_ff)
                        fwd_value = i_fwd.alu_value_ff;
                else if (idx == i_fwd.mem_dest_idx && i_fwd.mem_dav_ff)
                        fwd_value = i_fwd.mem_value_ff;
                else
                        fwd_value = i_rd_data;
        end

        // Memory accelerator.
        // Load data sitting in the memory stage is taken directly instead
        // of waiting for writeback.
        assign accel_hit = is_reg &&
                           i_fwd.mem_load &&
                           i_fwd.mem_dav_ff &&
                           idx == i_fwd.mem_srcdest_idx;

        assign o_value = accel_hit ? i_fwd.mem_load_data : fwd_value;

endmodule

// ==== verilog/issue_hazard_detector.sv ====
`timescale 1ns/1ps

module issue_hazard_detector (
        input  issue_pkg::decode_pkt_t i_decode,
        input  issue_pkg::issue_ctrl_t i_issued_ctrl,
        input  logic                   i_alu_dav_nxt,
        input  logic                   i_alu_dav_ff,
        input  issue_pkg::load_track_t i_load_track,
        output logic                   o_lock,
        output logic                   o_shifter_disable
);

        issue_pkg::operand_t [2:0] ops;
        logic                      issued_valid;
        logic                      needs_shifter;
        logic                      shift_hit;
        logic                      shift_lock;
        logic                      load_lock;
        logic                      all_immed;

        // True for a register operand whose index equals idx.
        function automatic logic reg_match(
                input issue_pkg::operand_t op,
                input issue_pkg::phy_idx_t idx
        );
                reg_match = !op.immed && (op.val[issue_pkg::IDX_W-1:0] == idx);
        endfunction

        assign ops = {i_decode.shift_length, i_decode.shift_source, i_decode.alu_source};

        assign issued_valid = (i_issued_ctrl.cond != issue_pkg::COND_NV);

        // LSL #0 needs no shifter at all.
        assign o_shifter_disable = (i_decode.ctrl.shift_op == issue_pkg::SHIFT_LSL) &&
                                   i_decode.shift_length.immed &&
                                   (i_decode.shift_length.val == '0);

        // RORI carries its own operands, so only real shifts and MLA care
        // about the result still sitting in our output register.
        assign needs_shifter = (!o_shifter_disable &&
                                i_decode.ctrl.shift_op != issue_pkg::SHIFT_RORI) ||
                               (i_decode.ctrl.alu_op == issue_pkg::ALU_MLA);

        always_comb
        begin
                shift_hit = 1'b0;
                load_lock = 1'b0;
                for (int i = 0; i < 3; i++)
                begin
                        if (issued_valid && reg_match(ops[i], i_issued_ctrl.dest_idx))
                                shift_hit = 1'b1;

                        // Loads in the issue output, shifter and ALU stages.
                        if ((reg_match(ops[i], i_issued_ctrl.mem_srcdest_idx) &&
                             issued_valid && i_issued_ctrl.mem_load) ||
                            (reg_match(ops[i], i_load_track.shifter_mem_srcdest_idx) &&
                             i_alu_dav_nxt && i_load_track.shifter_mem_load) ||
                            (reg_match(ops[i], i_load_track.alu_mem_srcdest_idx) &&
                             i_alu_dav_ff && i_load_track.alu_mem_load))
                                load_lock = 1'b1;
                end
        end

        assign shift_lock = needs_shifter && shift_hit;
        assign o_lock     = shift_lock || load_lock;

        assign all_immed = i_decode.alu_source.immed &&
                           i_decode.shift_source.immed &&
                           i_decode.shift_length.immed;

        // An instruction without register reads has nothing to wait for.
        always_comb
        begin
                if (all_immed)
                        assert (!o_lock)
                        else $error("lock raised for an immediate-only instruction");
        end

endmodule

// ==== verilog/issue_pipe_reg.sv ====
`timescale 1ns/1ps

module issue_pipe_reg (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_data_stall,
        input  logic                  i_clear_from_alu,
        input  logic                  i_stall_from_shifter,
        input  logic                  i_lock,
        input  issue_pkg::issue_pkt_t i_next,
        output issue_pkg::issue_pkt_t o_issue
);

        issue_pkg::issue_pkt_t bubble;

        // A bubble is an instruction that never executes.
        always_comb
        begin
                bubble           = '0;
                bubble.ctrl.cond = issue_pkg::COND_NV;
        end

        // Data stall outranks the ALU clear, which outranks the shifter
        // stall; a lock only matters when nothing downstream holds us.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        o_issue <= bubble;
                else if (i_data_stall)
                        o_issue <= o_issue;
                else if (i_clear_from_alu)
                        o_issue <= bubble;
                else if (i_stall_from_shifter)
                        o_issue <= o_issue;
                else if (i_lock)
                        o_issue <= bubble;
                else
                        o_issue <= i_next;
        end

        // Memory stall freezes the whole front end including this stage.
        a_data_stall_hold: assert property (
                @(posedge i_clk) disable iff (i_reset)
                i_data_stall |=> $stable(o_issue)
        ) else $error("o_issue changed under data stall");

        a_reset_bubble: assert property (
                @(posedge i_clk)
                i_reset |=> (o_issue.ctrl.cond == issue_pkg::COND_NV)
        ) else $error("o_issue not a bubble after reset");

endmodule

// ==== verilog/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage (
        input  logic                   i_clk,
        input  logic                   i_reset,
        // Writeback flush is handled by the clears further down the pipe.
        input  logic                   i_clear_from_writeback,
        input  logic                   i_data_stall,
        input  logic                   i_clear_from_alu,
        input  logic                   i_stall_from_shifter,
        input  issue_pkg::decode_pkt_t i_decode,
        input  issue_pkg::fwd_bus_t    i_fwd,
        input  issue_pkg::load_track_t i_load_track,
        input  issue_pkg::word_t       i_rd_data_0,
        input  issue_pkg::word_t       i_rd_data_1,
        input  issue_pkg::word_t       i_rd_data_2,
        input  issue_pkg::word_t       i_rd_data_3,
        output issue_pkg::phy_idx_t    o_rd_index_0,
        output issue_pkg::phy_idx_t    o_rd_index_1,
        output issue_pkg::phy_idx_t    o_rd_index_2,
        output issue_pkg::phy_idx_t    o_rd_index_3,
        output issue_pkg::issue_pkt_t  o_issue,
        output logic                   o_stall_from_issue
);

        issue_pkg::operand_t   store_operand;
        issue_pkg::operand_t   [3:0] operands;
        issue_pkg::word_t      [3:0] rd_data;
        issue_pkg::word_t      [3:0] values;
        issue_pkg::issue_pkt_t next_pkt;
        logic                  lock;
        logic                  shifter_disable;

        // Store data is always the register named by the memory index.
        always_comb
        begin
                store_operand = '0;
                store_operand.val[issue_pkg::IDX_W-1:0] = i_decode.ctrl.mem_srcdest_idx;
        end

        assign operands = {store_operand, i_decode.shift_length,
                           i_decode.shift_source, i_decode.alu_source};
        assign rd_data  = {i_rd_data_3, i_rd_data_2, i_rd_data_1, i_rd_data_0};

        // One register file read port per operand.
        assign o_rd_index_0 = operands[0].val[issue_pkg::IDX_W-1:0];
        assign o_rd_index_1 = operands[1].val[issue_pkg::IDX_W-1:0];
        assign o_rd_index_2 = operands[2].val[issue_pkg::IDX_W-1:0];
        assign o_rd_index_3 = operands[3].val[issue_pkg::IDX_W-1:0];

        for (genvar g = 0; g < 4; g++)
        begin : g_res
                operand_resolver operand_resolver_i (
                        .i_operand   (operands[g]),
                        .i_pc_plus_8 (i_decode.pc_plus_8),
                        .i_rd_data   (rd_data[g]),
                        .i_fwd       (i_fwd),
                        .o_value     (values[g])
                );
        end

        issue_hazard_detector issue_hazard_detector_i (
                .i_decode          (i_decode),
                .i_issued_ctrl     (o_issue.ctrl),
                .i_alu_dav_nxt     (i_fwd.alu_dav_nxt),
                .i_alu_dav_ff      (i_fwd.alu_dav_ff),
                .i_load_track      (i_load_track),
                .o_lock            (lock),
                .o_shifter_disable (shifter_disable)
        );

        always_comb
        begin
                next_pkt.ctrl               = i_decode.ctrl;
                next_pkt.pc_plus_8          = i_decode.pc_plus_8;
                next_pkt.alu_source         = i_decode.alu_source;
                next_pkt.shift_source       = i_decode.shift_source;
                next_pkt.shift_length       = i_decode.shift_length;
                next_pkt.alu_source_value   = values[0];
                next_pkt.shift_source_value = values[1];
                next_pkt.shift_length_value = values[2];
                next_pkt.mem_srcdest_value  = values[3];
                next_pkt.shifter_disable    = shifter_disable;
        end

        issue_pipe_reg issue_pipe_reg_i (
                .i_clk                (i_clk),
                .i_reset              (i_reset),
                .i_data_stall         (i_data_stall),
                .i_clear_from_alu     (i_clear_from_alu),
                .i_stall_from_shifter (i_stall_from_shifter),
                .i_lock               (lock),
                .i_next               (next_pkt),
                .o_issue              (o_issue)
        );

        // Decode and fetch hold while the lock stands.
        assign o_stall_from_issue = lock;

endmodule

// ==== include/issue_tb_model.svh ====
`ifndef ISSUE_TB_MODEL_SVH
`define ISSUE_TB_MODEL_SVH

// A matching load in the memory stage beats every other source.
function automatic issue_pkg::word_t resolve_operand(
        input issue_pkg::operand_t op,
        input issue_pkg::word_t    pc_plus_8,
        input issue_pkg::word_t    rd,
        input issue_pkg::fwd_bus_t f
);
        issue_pkg::phy_idx_t idx;
        idx = issue_pkg::phy_idx_t'(op.val);
        if (op.immed)
                return op.val;
        if (f.mem_load && f.mem_dav_ff && idx == f.mem_srcdest_idx)
                return f.mem_load_data;
        if (idx == issue_pkg::ARCH_PC)
                return pc_plus_8;
        if (f.alu_dav_nxt && idx == f.shifter_dest_idx)
                return f.alu_value_nxt;
        if (f.alu_dav_ff && idx == f.alu_dest_idx)
                return f.alu_value_ff;
        if (f.mem_dav_ff && idx == f.mem_dest_idx)
                return f.mem_value_ff;
        return rd;
endfunction

function automatic bit expect_shifter_disable(input issue_pkg::decode_pkt_t d);
        return d.ctrl.shift_op == issue_pkg::SHIFT_LSL && d.shift_length.immed &&
               d.shift_length.val == 32'd0;
endfunction

// Shift lock against the issued instruction and load lock against three loads.
function automatic bit expect_lock(
        input issue_pkg::decode_pkt_t d,
        input issue_pkg::issue_ctrl_t q,
        input issue_pkg::fwd_bus_t    f,
        input issue_pkg::load_track_t t
);
        issue_pkg::operand_t ops [3];
        issue_pkg::phy_idx_t idx;
        bit                  shifting;
        bit                  dest_hit;
        bit                  load_hit;
        ops      = '{d.alu_source, d.shift_source, d.shift_length};
        shifting = d.ctrl.alu_op == issue_pkg::ALU_MLA ||
                   (!expect_shifter_disable(d) && d.ctrl.shift_op != issue_pkg::SHIFT_RORI);
        dest_hit = 1'b0;
        load_hit = 1'b0;
        foreach (ops[i])
        begin
                idx = issue_pkg::phy_idx_t'(ops[i].val);
                if (!ops[i].immed)
                begin
                        dest_hit |= q.cond != issue_pkg::COND_NV && idx == q.dest_idx;
                        load_hit |= q.cond != issue_pkg::COND_NV && q.mem_load &&
                                    idx == q.mem_srcdest_idx;
                        load_hit |= f.alu_dav_nxt && t.shifter_mem_load &&
                                    idx == t.shifter_mem_srcdest_idx;
                        load_hit |= f.alu_dav_ff && t.alu_mem_load &&
                                    idx == t.alu_mem_srcdest_idx;
                end
        end
        return (shifting && dest_hit) || load_hit;
endfunction

function automatic issue_pkg::issue_pkt_t bubble_pkt();
        issue_pkg::issue_pkt_t b;
        b           = '0;
        b.ctrl.cond = issue_pkg::COND_NV;
        return b;
endfunction

// Output register after the next edge outside of reset.
function automatic issue_pkg::issue_pkt_t next_expected(
        input issue_pkg::issue_pkt_t    cur,
        input issue_pkg::decode_pkt_t   d,
        input issue_pkg::fwd_bus_t      f,
        input issue_pkg::load_track_t   t,
        input issue_pkg::word_t   [3:0] rd,
        input bit                       data_stall,
        input bit                       clear_alu,
        input bit                       stall_shifter
);
        issue_pkg::issue_pkt_t nxt;
        issue_pkg::operand_t   st;
        if (data_stall || (!clear_alu && stall_shifter))
                return cur;
        if (clear_alu || expect_lock(d, cur.ctrl, f, t))
                return bubble_pkt();
        st                     = {1'b0, issue_pkg::word_t'(d.ctrl.mem_srcdest_idx)};
        nxt.ctrl               = d.ctrl;
        nxt.pc_plus_8          = d.pc_plus_8;
        nxt.alu_source         = d.alu_source;
        nxt.shift_source       = d.shift_source;
        nxt.shift_length       = d.shift_length;
        nxt.alu_source_value   = resolve_operand(d.alu_source, d.pc_plus_8, rd[0], f);
        nxt.shift_source_value = resolve_operand(d.shift_source, d.pc_plus_8, rd[1], f);
        nxt.shift_length_value = resolve_operand(d.shift_length, d.pc_plus_8, rd[2], f);
        nxt.mem_srcdest_value  = resolve_operand(st, d.pc_plus_8, rd[3], f);
        nxt.shifter_disable    = expect_shifter_disable(d);
        return nxt;
endfunction

task automatic compare_issue_pkt(input issue_pkg::issue_pkt_t got, exp, input string what);
        if (got !== exp)
                report_error($sformatf("%s is %h, expected %h", what, got, exp));
endtask

task automatic compare_word(input issue_pkg::word_t got, exp, input string what);
        if (got !== exp)
                report_error($sformatf("%s is %h, expected %h", what, got, exp));
endtask

task automatic compare_idx(input issue_pkg::phy_idx_t got, exp, input string what);
        if (got !== exp)
                report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
endtask

task automatic compare_bit(input bit got, exp, input string what);
        if (got !== exp)
                report_error($sformatf("%s is %b, expected %b", what, got, exp));
endtask

`endif

// ==== sim/issue_stage_tb.sv ====
`timescale 1ns/1ps

module issue_stage_tb;

        localparam int CLK_PERIOD    = 4;
        localparam int RESET_CYCLES  = 5;
        localparam int RANDOM_CYCLES = 2000;
        localparam int TEST_CYCLES   = RESET_CYCLES + RANDOM_CYCLES + 2;

        logic                         i_clk;
        logic                         i_reset;
        logic                         i_clear_from_writeback;
        logic                         i_data_stall;
        logic                         i_clear_from_alu;
        logic                         i_stall_from_shifter;
        issue_pkg::decode_pkt_t       i_decode;
        issue_pkg::fwd_bus_t          i_fwd;
        issue_pkg::load_track_t       i_load_track;
        issue_pkg::word_t       [3:0] rd_data;
        issue_pkg::phy_idx_t    [3:0] rd_index;
        issue_pkg::issue_pkt_t        o_issue;
        logic                         o_stall_from_issue;
        issue_pkg::issue_pkt_t        exp_issue;
        logic                  [31:0] lfsr = 32'hdd82;
        int                           checked;

        issue_stage issue_stage_i (
                .*,
                .i_rd_data_0  (rd_data[0]),
                .i_rd_data_1  (rd_data[1]),
                .i_rd_data_2  (rd_data[2]),
                .i_rd_data_3  (rd_data[3]),
                .o_rd_index_0 (rd_index[0]),
                .o_rd_index_1 (rd_index[1]),
                .o_rd_index_2 (rd_index[2]),
                .o_rd_index_3 (rd_index[3])
        );

        task automatic report_error(input string msg);
                $display("[ERROR] %0t ns: %s", $time, msg);
                $display("Finished with errors");
                $fatal(1, "stopped at the first mismatch");
        endtask

        `include "issue_tb_model.svh"

        // Galois LFSR stepped once per bit taken.
        function automatic logic [31:0] lfsr_bits(input int n);
                logic [31:0] r;
                r = '0;
                for (int i = 0; i < n; i++)
                begin
                        lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
                        r    = {r[30:0], lfsr[0]};
                end
                return r;
        endfunction

        // Few indices, so that forwarding and locks hit often.
        function automatic issue_pkg::phy_idx_t random_index();
                return lfsr_bits(3) == 0 ? issue_pkg::ARCH_PC : issue_pkg::phy_idx_t'(lfsr_bits(2));
        endfunction

        function automatic issue_pkg::operand_t random_operand();
                issue_pkg::operand_t op;
                op.immed = lfsr_bits(2) == 0;
                if (op.immed)
                        op.val = lfsr_bits(1) == 0 ? 32'd0 : lfsr_bits(32);
                else
                        op.val = issue_pkg::word_t'(random_index());
                return op;
        endfunction

        task automatic drive_random();
                issue_pkg::decode_pkt_t d;
                issue_pkg::fwd_bus_t    f;
                issue_pkg::load_track_t t;
                d.ctrl                 = {4'(lfsr_bits(4)), lfsr_bits(32)};
                d.ctrl.dest_idx        = random_index();
                d.ctrl.mem_srcdest_idx = random_index();
                if (lfsr_bits(2) == 0)
                        d.ctrl.alu_op = issue_pkg::ALU_MLA;
                if (lfsr_bits(1) == 0)
                        d.ctrl.shift_op = issue_pkg::SHIFT_LSL;
                else if (lfsr_bits(2) == 0)
                        d.ctrl.shift_op = issue_pkg::SHIFT_RORI;
                d.pc_plus_8    = lfsr_bits(32);
                d.alu_source   = random_operand();
                d.shift_source = random_operand();
                d.shift_length = random_operand();
                f = {28'(lfsr_bits(28)), lfsr_bits(32), lfsr_bits(32), lfsr_bits(32),
                     lfsr_bits(32)};
                f.shifter_dest_idx        = random_index();
                f.alu_dest_idx            = random_index();
                f.mem_dest_idx            = random_index();
                f.mem_srcdest_idx         = random_index();
                t                         = 14'(lfsr_bits(14));
                t.shifter_mem_srcdest_idx = random_index();
                t.alu_mem_srcdest_idx     = random_index();
                i_decode               <= d;
                i_fwd                  <= f;
                i_load_track           <= t;
                rd_data                <= {lfsr_bits(32), lfsr_bits(32), lfsr_bits(32),
                                           lfsr_bits(32)};
                i_data_stall           <= lfsr_bits(3) == 0;
                i_clear_from_alu       <= lfsr_bits(3) == 0;
                i_stall_from_shifter   <= lfsr_bits(3) == 0;
                i_clear_from_writeback <= lfsr_bits(4) == 0;
        endtask

        initial
        begin
                i_clk = 1'b0;
                forever
                        #(CLK_PERIOD / 2) i_clk = ~i_clk;
        end

        initial
        begin
                #(TEST_CYCLES * CLK_PERIOD * 3 / 2);
                $display("Watchdog timeout, the test did not reach its end in time");
                $display("Finished with errors");
                $fatal(1, "watchdog timeout");
        end

        initial
        begin
                i_reset                = 1'b1;
                i_clear_from_writeback = 1'b0;
                i_data_stall           = 1'b0;
                i_clear_from_alu       = 1'b0;
                i_stall_from_shifter   = 1'b0;
                i_decode               = '0;
                i_fwd                  = '0;
                i_load_track           = '0;
                rd_data                = '0;
                repeat (RESET_CYCLES) @(posedge i_clk);
                i_reset <= 1'b0;
                repeat (RANDOM_CYCLES)
                begin
                        @(posedge i_clk);
                        drive_random();
                end
                repeat (2) @(posedge i_clk);
                if (checked < RANDOM_CYCLES)
                begin
                        $display("Compare process ran only %0d cycles", checked);
                        $display("Finished with errors");
                        $fatal(1, "too few checks");
                end
                else
                begin
                        $display("Finished with no errors");
                        $finish;
                end
        end

        // Inputs and outputs are settled at the falling edge.
        initial
        begin
                checked = 0;
                @(negedge i_reset);
                exp_issue = bubble_pkt();
                forever
                begin
                        @(negedge i_clk);
                        compare_idx(rd_index[0], issue_pkg::phy_idx_t'(i_decode.alu_source.val),
                                    "read index 0");
                        compare_idx(rd_index[1], issue_pkg::phy_idx_t'(i_decode.shift_source.val),
                                    "read index 1");
                        compare_idx(rd_index[2], issue_pkg::phy_idx_t'(i_decode.shift_length.val),
                                    "read index 2");
                        compare_idx(rd_index[3], i_decode.ctrl.mem_srcdest_idx, "read index 3");
                        compare_bit(o_stall_from_issue,
                                    expect_lock(i_decode, exp_issue.ctrl, i_fwd, i_load_track),
                                    "o_stall_from_issue");
                        compare_word(o_issue.alu_source_value, exp_issue.alu_source_value,
                                     "alu source value");
                        compare_word(o_issue.shift_source_value, exp_issue.shift_source_value,
                                     "shift source value");
                        compare_word(o_issue.shift_length_value, exp_issue.shift_length_value,
                                     "shift length value");
                        compare_word(o_issue.mem_srcdest_value, exp_issue.mem_srcdest_value,
                                     "store data value");
                        compare_issue_pkt(o_issue, exp_issue, "o_issue");
                        exp_issue = next_expected(exp_issue, i_decode, i_fwd, i_load_track,
                                                  rd_data, i_data_stall, i_clear_from_alu,
                                                  i_stall_from_shifter);
                        checked++;
                end
        end

endmodule

// ==== compile.f ====
+incdir+include
verilog/issue_pkg.sv
verilog/operand_resolver.sv
verilog/issue_hazard_detector.sv
verilog/issue_pipe_reg.sv
verilog/issue_stage.sv
sim/issue_stage_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := issue_stage_tb
FILELIST := compile.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(wildcard verilog/*.sv sim/*.sv include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
